// ==== ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

    // Transfer type driven on HTRANS
    typedef enum logic [1:0] {
        IDLE   = 2'b00,                       // No transfer
        BUSY   = 2'b01,                       // Burst pause
        NONSEQ = 2'b10,                       // Single or first beat
        SEQ    = 2'b11                        // Later burst beat
    } htrans_t;

    // HSIZE encoding for a 32-bit beat
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Single transfer, no burst
    localparam logic [2:0] HBURST_SINGLE = 3'b000;

    // Data access in privileged mode
    // Not bufferable and not cacheable
    localparam logic [3:0] HPROT_DATA_PRIV = 4'b0011;

endpackage : ahb_pkg

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI = 7'b0110111,                  // Load upper immediate
        OP_IMM = 7'b0010011,                  // Register-immediate ALU
        OP_REG = 7'b0110011                   // Register-register ALU
    } opcode_t;

    typedef logic [4:0] reg_idx_t;            // x0 to x31

    // funct3 selects the ALU operation
    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // funct7 of R-type ops
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

    // R-type field layout, also valid for the I-type rd/rs1/funct3 bits
    typedef struct packed {
        logic [6:0] funct7;                   // Top of I-type immediate too
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } instr_r_t;

    // One prefetched word with its address
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // Retire report, one per executed word
    typedef struct packed {
        logic        valid;                   // Retirement this cycle
        logic        illegal;                 // Unsupported encoding
        logic [31:0] pc;
        reg_idx_t    rd;                      // Zero for illegal words
        logic [31:0] value;                   // Zero for illegal words
    } retire_t;

endpackage : rv_pkg

`default_nettype wire

// ==== ahb_fetch_master.sv ====
`default_nettype none

module ahb_fetch_master #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire  [31:0]          i_hrdata,           // Read data bus
    input  wire                  i_hready,           // Data phase done
    input  wire                  i_fifo_almost_full, // At most one slot left
    output logic [31:0]          o_haddr,
    output ahb_pkg::htrans_t     o_htrans,
    output logic [2:0]           o_hsize,
    output logic [2:0]           o_hburst,
    output logic [3:0]           o_hprot,
    output logic                 o_hwrite,
    output logic                 o_hmastlock,
    output logic                 o_push,             // Word returned this cycle
    output rv_pkg::fetch_entry_t o_push_entry
);

    typedef enum logic {
        ADDR,                                        // Waiting for FIFO room
        DATA                                         // Transfer outstanding
    } state_t;

    state_t      state;
    logic [31:0] fetch_pc;                           // Address of word in flight
    logic [31:0] next_pc;
    logic        data_phase;

    assign next_pc = fetch_pc + 32'd4;

    // Address phase is the DATA cycle still showing NONSEQ
    assign data_phase = (state == DATA) && (o_htrans == ahb_pkg::IDLE);
    assign o_push     = data_phase && i_hready;      // Capture on HREADY high

    assign o_push_entry.pc    = fetch_pc;
    assign o_push_entry.instr = i_hrdata;

    assign o_haddr     = fetch_pc;                   // Only sampled with NONSEQ
    assign o_hsize     = ahb_pkg::HSIZE_WORD;
    assign o_hburst    = ahb_pkg::HBURST_SINGLE;
    assign o_hprot     = ahb_pkg::HPROT_DATA_PRIV;
    assign o_hwrite    = 1'b0;                       // Read only
    assign o_hmastlock = 1'b0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ADDR;
            o_htrans <= ahb_pkg::IDLE;
            fetch_pc <= RESET_PC;
        end else begin
            o_htrans <= ahb_pkg::IDLE;               // NONSEQ lasts one cycle
            case (state)
                ADDR: begin
                    if (!i_fifo_almost_full) begin
                        o_htrans <= ahb_pkg::NONSEQ; // Issue at fetch_pc
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (o_push) begin
                        fetch_pc <= next_pc;
                        // Count excludes this push, so room stays for the next word
                        if (!i_fifo_almost_full) begin
                            o_htrans <= ahb_pkg::NONSEQ; // Back-to-back issue
                        end else begin
                            state <= ADDR;           // Wait for drain
                        end
                    end
                end
            endcase
        end
    end

    // Only single transfers on this bus
    a_htrans_legal : assert property (@(posedge clk) disable iff (!reset_n)
        o_htrans inside {ahb_pkg::IDLE, ahb_pkg::NONSEQ})
        else $error("HTRANS BUSY or SEQ driven");

    // Every word pushed was issued while the FIFO had a spare slot
    a_issue_room : assert property (@(posedge clk) disable iff (!reset_n)
        (o_htrans == ahb_pkg::NONSEQ) |-> !$past(i_fifo_almost_full))
        else $error("Fetch issued with FIFO almost full");

endmodule : ahb_fetch_master

`default_nettype wire

// ==== fetch_fifo.sv ====
`default_nettype none

module fetch_fifo #(
    parameter int FIFO_DEPTH = 4                     // Power of two
) (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       i_push,
    input  wire rv_pkg::fetch_entry_t i_push_entry,
    input  wire                       i_pop,
    output rv_pkg::fetch_entry_t      o_head,        // Oldest entry
    output logic                      o_empty,
    output logic                      o_almost_full  // Count >= depth - 1
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;                // Holds 0 to depth

    rv_pkg::fetch_entry_t mem [FIFO_DEPTH];          // Payload storage

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign o_head        = mem[rd_ptr];
    assign o_empty       = (count == '0);
    assign full          = (count == CNT_W'(FIFO_DEPTH));
    assign o_almost_full = (count >= CNT_W'(FIFO_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_entry;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);        // Wraps at depth
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;             // Idle or both at once
            endcase
        end
    end

    a_no_overflow : assert property (@(posedge clk) disable iff (!reset_n)
        !(i_push && full))
        else $error("Push into full FIFO");

    a_no_underflow : assert property (@(posedge clk) disable iff (!reset_n)
        !(i_pop && o_empty))
        else $error("Pop from empty FIFO");

endmodule : fetch_fifo

`default_nettype wire

// ==== rv_exec_unit.sv ====
`default_nettype none

module rv_exec_unit (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire rv_pkg::fetch_entry_t i_head,        // FIFO head entry
    input  wire                       i_empty,
    input  wire                       i_debug_stall, // Holds execution
    output logic                      o_pop,
    output rv_pkg::retire_t           o_retire
);

    logic [31:0]      regs [32];                     // x0 slot never read
    rv_pkg::instr_r_t ir;
    logic [31:0]      imm_i;
    logic [31:0]      imm_u;
    logic [31:0]      rs1_val;
    logic [31:0]      rs2_val;
    logic [31:0]      result;
    logic             legal;
    logic             rd_write;

    assign o_pop = !i_empty && !i_debug_stall;       // One entry per cycle

    assign ir    = i_head.instr;
    assign imm_i = {{20{i_head.instr[31]}}, i_head.instr[31:20]}; // Sign-extended
    assign imm_u = {i_head.instr[31:12], 12'b0};

    // x0 reads as zero
    assign rs1_val = (ir.rs1 == '0) ? 32'd0 : regs[ir.rs1];
    assign rs2_val = (ir.rs2 == '0) ? 32'd0 : regs[ir.rs2];

    always_comb begin
        result = 32'd0;
        legal  = 1'b0;
        case (ir.opcode)
            rv_pkg::OP_LUI: begin
                legal  = 1'b1;
                result = imm_u;
            end
            rv_pkg::OP_IMM: begin
                legal = 1'b1;
                case (ir.funct3)
                    rv_pkg::FUNCT3_ADD: result = rs1_val + imm_i;
                    rv_pkg::FUNCT3_XOR: result = rs1_val ^ imm_i;
                    rv_pkg::FUNCT3_OR:  result = rs1_val | imm_i;
                    rv_pkg::FUNCT3_AND: result = rs1_val & imm_i;
                    default:            legal  = 1'b0; // SLTI and shifts
                endcase
            end
            rv_pkg::OP_REG: begin
                if (ir.funct7 == rv_pkg::FUNCT7_BASE) begin
                    legal = 1'b1;
                    case (ir.funct3)
                        rv_pkg::FUNCT3_ADD: result = rs1_val + rs2_val;
                        rv_pkg::FUNCT3_XOR: result = rs1_val ^ rs2_val;
                        rv_pkg::FUNCT3_OR:  result = rs1_val | rs2_val;
                        rv_pkg::FUNCT3_AND: result = rs1_val & rs2_val;
                        default:            legal  = 1'b0; // Shifts and compares
                    endcase
                end else if (ir.funct7 == rv_pkg::FUNCT7_SUB &&
                             ir.funct3 == rv_pkg::FUNCT3_ADD) begin
                    legal  = 1'b1;
                    result = rs1_val - rs2_val;
                end
            end
            default: legal = 1'b0;                   // Outside the subset
        endcase
    end

    assign rd_write = o_pop && legal && (ir.rd != '0);

    always_ff @(posedge clk) begin
        if (rd_write) begin
            regs[ir.rd] <= result;
        end
    end

    // Retire report one cycle after the pop
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_retire <= '0;
        end else begin
            o_retire.valid   <= o_pop;
            o_retire.illegal <= o_pop && !legal;
            o_retire.pc      <= i_head.pc;
            o_retire.rd      <= legal ? ir.rd : '0;
            o_retire.value   <= legal ? result : 32'd0; // x0 target still reports value
        end
    end

    a_retire_after_pop : assert property (@(posedge clk) disable iff (!reset_n)
        o_retire.valid |-> $past(o_pop))
        else $error("Retire without a pop");

endmodule : rv_exec_unit

`default_nettype wire

// ==== rv_fetch_exec_top.sv ====
`default_nettype none

module rv_fetch_exec_top #(
    parameter logic [31:0] RESET_PC   = 32'h0000_0000,
    parameter int          FIFO_DEPTH = 4
) (
    input  wire              clk,
    input  wire              reset_n,
    input  wire              i_debug_stall,
    input  wire  [31:0]      i_hrdata,
    input  wire              i_hready,
    output logic [31:0]      o_haddr,
    output ahb_pkg::htrans_t o_htrans,
    output logic [2:0]       o_hsize,
    output logic [2:0]       o_hburst,
    output logic [3:0]       o_hprot,
    output logic             o_hwrite,
    output logic             o_hmastlock,
    output rv_pkg::retire_t  o_retire
);

    logic                 push;                      // Fetch to FIFO
    rv_pkg::fetch_entry_t push_entry;
    logic                 almost_full;               // FIFO to fetch
    logic                 empty;                     // FIFO to execute
    rv_pkg::fetch_entry_t head;
    logic                 pop;                       // Execute to FIFO

    ahb_fetch_master #(
        .RESET_PC (RESET_PC)
    ) u_ahb_fetch_master (
        .clk                (clk),
        .reset_n            (reset_n),
        .i_hrdata           (i_hrdata),
        .i_hready           (i_hready),
        .i_fifo_almost_full (almost_full),
        .o_haddr            (o_haddr),
        .o_htrans           (o_htrans),
        .o_hsize            (o_hsize),
        .o_hburst           (o_hburst),
        .o_hprot            (o_hprot),
        .o_hwrite           (o_hwrite),
        .o_hmastlock        (o_hmastlock),
        .o_push             (push),
        .o_push_entry       (push_entry)
    );

    fetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetch_fifo (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_push        (push),
        .i_push_entry  (push_entry),
        .i_pop         (pop),
        .o_head        (head),
        .o_empty       (empty),
        .o_almost_full (almost_full)
    );

    rv_exec_unit u_rv_exec_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_head        (head),
        .i_empty       (empty),
        .i_debug_stall (i_debug_stall),
        .o_pop         (pop),
        .o_retire      (o_retire)
    );

endmodule : rv_fetch_exec_top

`default_nettype wire

// ==== tb_ahb_mem.sv ====
`default_nettype none

module tb_ahb_mem #(
    parameter int          MEM_WORDS = 128,
    parameter logic [31:0] SEED      = 32'h0000_0001
) (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire  [31:0]           i_haddr,
    input  wire ahb_pkg::htrans_t i_htrans,
    output logic [31:0]           o_hrdata,
    output logic                  o_hready
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];                    // Program image from tb_top
    logic [31:0] addr_q;                             // Address of the open transfer
    logic        busy;                               // Data phase pending
    int unsigned left;                               // Wait states still to insert

    // Out-of-range reads return ADDI x0, x0, 0
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr[31:AW+2] == '0) begin
            return mem[addr[AW+1:2]];
        end
        return 32'h0000_0013;
    endfunction

    // Outputs change on the falling edge only
    initial begin
        void'($urandom(SEED));                       // Same process draws the waits
        o_hready = 1'b1;
        o_hrdata = 32'd0;
        addr_q   = 32'd0;
        busy     = 1'b0;
        left     = 0;
        forever begin
            @(negedge clk);
            if (!reset_n) begin
                busy     = 1'b0;
                o_hready = 1'b1;
            end else if (i_htrans == ahb_pkg::NONSEQ) begin
                addr_q   = i_haddr;                  // Address phase
                left     = $urandom % 4;             // 0 to 3 wait states
                busy     = 1'b1;
                o_hready = 1'b1;
            end else if (busy) begin
                if (left == 0) begin
                    o_hready = 1'b1;                 // Last data cycle
                    o_hrdata = read_word(addr_q);
                    busy     = 1'b0;
                end else begin
                    o_hready = 1'b0;
                    o_hrdata = ~addr_q;              // Junk while waiting
                    left     = left - 1;
                end
            end else begin
                o_hready = 1'b1;                     // Idle bus
            end
        end
    end

endmodule : tb_ahb_mem

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none

module tb_top;

    localparam logic [31:0] RESET_PC       = 32'h0000_0000;
    localparam int          FIFO_DEPTH     = 4;
    localparam int          MEM_WORDS      = 128;
    localparam int          AW             = $clog2(MEM_WORDS);
    localparam int          NUM_CHECK      = 64;   // Program plus padding
    localparam int          STALL_AT       = 12;
    localparam int          STALL_CYCLES   = 30;
    localparam int          FILL_CYCLES    = (FIFO_DEPTH + 1) * 5; // Worst-case waits
    localparam int          TIMEOUT_CYCLES = 1000;

    logic                   clk;
    logic                   reset_n;
    logic                   debug_stall;
    logic [31:0]            hrdata;
    logic                   hready;
    logic [31:0]            haddr;
    ahb_pkg::htrans_t       htrans;
    logic [2:0]             hsize;
    logic [2:0]             hburst;
    logic [3:0]             hprot;
    logic                   hwrite;
    logic                   hmastlock;
    rv_pkg::retire_t        retire;

    logic [31:0] image [MEM_WORDS];
    logic [31:0] model_regs [32];                    // ISA view of x0..x31
    int          prog_len = 0;
    int          retired = 0;
    int          error_count = 0;
    int          stall_len = 0;
    int          stall_fetches = 0;
    logic [31:0] next_fetch = RESET_PC;
    logic [31:0] exp_pc = RESET_PC;
    logic        active = 1'b0;                      // Reset seen high at last posedge
    logic        stall_seen = 1'b0;                  // Stall seen at last posedge

    rv_fetch_exec_top #(
        .RESET_PC   (RESET_PC),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rv_fetch_exec_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_debug_stall (debug_stall),
        .i_hrdata      (hrdata),
        .i_hready      (hready),
        .o_haddr       (haddr),
        .o_htrans      (htrans),
        .o_hsize       (hsize),
        .o_hburst      (hburst),
        .o_hprot       (hprot),
        .o_hwrite      (hwrite),
        .o_hmastlock   (hmastlock),
        .o_retire      (retire)
    );

    tb_ahb_mem #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (32'h709b)
    ) u_ahb_mem (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_haddr  (haddr),
        .i_htrans (htrans),
        .o_hrdata (hrdata),
        .o_hready (hready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] op_imm(input logic [2:0] f3, input int rd, input int rs1,
                                           input logic [11:0] imm);
        return {imm, rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] op_lui(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], 7'b0110111};
    endfunction

    // One ISA step, straight from the RV32I encoding tables
    function automatic rv_pkg::retire_t ref_step(input logic [31:0] pc, input logic [31:0] instr);
        rv_pkg::retire_t exp;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm;
        logic [31:0]     res;
        logic            ok;
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        imm = {{20{instr[31]}}, instr[31:20]};
        res = 32'd0;
        ok  = 1'b1;
        case (instr[6:0])
            7'b0110111: res = {instr[31:12], 12'h000};   // LUI
            7'b0010011: begin
                case (instr[14:12])
                    3'b000:  res = a + imm;
                    3'b100:  res = a ^ imm;
                    3'b110:  res = a | imm;
                    3'b111:  res = a & imm;
                    default: ok = 1'b0;
                endcase
            end
            7'b0110011: begin
                if (instr[31:25] == 7'b0100000 && instr[14:12] == 3'b000) begin
                    res = a - b;
                end else if (instr[31:25] == 7'b0000000) begin
                    case (instr[14:12])
                        3'b000:  res = a + b;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: ok = 1'b0;
                    endcase
                end else begin
                    ok = 1'b0;
                end
            end
            default: ok = 1'b0;
        endcase
        exp.valid   = 1'b1;
        exp.illegal = !ok;
        exp.pc      = pc;
        exp.rd      = ok ? instr[11:7] : 5'd0;
        exp.value   = ok ? res : 32'd0;
        if (ok && instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;           // x0 stays zero
        end
        return exp;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t o_retire got v=%b ill=%b pc=%h rd=%0d val=%h", $time,
                     got.valid, got.illegal, got.pc, got.rd, got.value);
            $display("        expected v=%b ill=%b pc=%h rd=%0d val=%h",
                     exp.valid, exp.illegal, exp.pc, exp.rd, exp.value);
            stop_with_failure("Retire port mismatch");
        end
    endtask

    task automatic check_request(input ahb_pkg::htrans_t got_trans, input logic [31:0] got_addr,
                                 input ahb_pkg::htrans_t exp_trans, input logic [31:0] exp_addr);
        if (got_trans !== exp_trans || got_addr !== exp_addr) begin
            error_count++;
            $display("[ERROR] %0t o_htrans/o_haddr got %s/%h expected %s/%h", $time,
                     got_trans.name(), got_addr, exp_trans.name(), exp_addr);
            stop_with_failure("Bus request mismatch");
        end
    endtask

    task automatic check_ctrl(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("Bus control mismatch");
        end
    endtask

    task automatic wait_retired(input int target);
        int cycles;
        cycles = 0;
        while (retired < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timeout, instructions stopped retiring");
            end
        end
    endtask

    task automatic put_word(input logic [31:0] word);
        image[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_program();
        put_word(op_lui(1, 20'h12345));
        put_word(op_imm(rv_pkg::FUNCT3_ADD, 1, 1, 12'h678));
        put_word(op_imm(rv_pkg::FUNCT3_ADD, 2, 0, 12'hFFF));             // -1
        put_word(op_imm(rv_pkg::FUNCT3_XOR, 3, 1, 12'h0F0));
        put_word(op_imm(rv_pkg::FUNCT3_OR, 4, 0, 12'h7FF));
        put_word(op_imm(rv_pkg::FUNCT3_AND, 5, 2, 12'hF00));             // Sign-extended mask
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 6, 1, 2));
        put_word(op_reg(rv_pkg::FUNCT7_SUB, rv_pkg::FUNCT3_ADD, 7, 1, 4));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_XOR, 8, 3, 1));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_OR, 9, 5, 4));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_AND, 10, 1, 5));
        put_word(op_imm(rv_pkg::FUNCT3_ADD, 0, 1, 12'h005));             // x0 target
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 11, 0, 1));
        put_word(op_lui(0, 20'hABCDE));
        put_word(op_imm(rv_pkg::FUNCT3_ADD, 31, 0, 12'h02A));
        put_word(32'hFFFF_FFFF);                                           // Illegal, rd field 31
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 12, 31, 0));
        put_word(op_imm(3'b001, 6, 1, 12'h001));                           // SLLI, not supported
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 13, 6, 0));
        put_word(op_reg(rv_pkg::FUNCT7_SUB, rv_pkg::FUNCT3_ADD, 14, 0, 1));
        put_word(op_lui(15, 20'hFFFFF));
        put_word(op_imm(rv_pkg::FUNCT3_OR, 15, 15, 12'h123));
        put_word(op_imm(rv_pkg::FUNCT3_XOR, 16, 15, 12'hFFF));           // Bitwise NOT
        put_word(op_imm(rv_pkg::FUNCT3_AND, 17, 16, 12'h0FF));
        put_word(op_reg(rv_pkg::FUNCT7_SUB, rv_pkg::FUNCT3_ADD, 18, 17, 15));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_XOR, 19, 18, 18));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_OR, 20, 19, 7));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_AND, 21, 20, 2));
        put_word(op_imm(rv_pkg::FUNCT3_ADD, 22, 21, 12'h800));           // -2048
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 23, 22, 22));
        put_word(op_reg(rv_pkg::FUNCT7_SUB, rv_pkg::FUNCT3_ADD, 24, 23, 1));
        put_word(op_imm(rv_pkg::FUNCT3_XOR, 25, 24, 12'h555));
        put_word(op_imm(rv_pkg::FUNCT3_OR, 26, 25, 12'hFF0));
        put_word(op_imm(rv_pkg::FUNCT3_AND, 27, 26, 12'h03C));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 28, 27, 9));
        put_word(op_reg(rv_pkg::FUNCT7_SUB, rv_pkg::FUNCT3_ADD, 29, 28, 10));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_XOR, 30, 29, 11));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_OR, 1, 30, 12));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 0, 1, 1));
        put_word(op_reg(rv_pkg::FUNCT7_BASE, rv_pkg::FUNCT3_ADD, 2, 0, 0));
        // Padding is ADDI x0 with the byte address as immediate
        for (int i = prog_len; i < MEM_WORDS; i++) begin
            image[i] = op_imm(rv_pkg::FUNCT3_ADD, 0, 0, 12'(i * 4));
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_ahb_mem.mem[i] = image[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
    endtask

    always @(posedge clk) begin
        active     <= reset_n;
        stall_seen <= debug_stall;
    end

    // Compare process, runs where DUT outputs are settled
    always @(negedge clk) begin
        rv_pkg::retire_t exp_retire;
        if (active) begin
            stall_len     = stall_seen ? stall_len + 1 : 0;
            stall_fetches = stall_seen ? stall_fetches : 0;
            if (htrans != ahb_pkg::IDLE) begin
                check_request(htrans, haddr, ahb_pkg::NONSEQ, next_fetch);
                check_ctrl("o_hsize", {1'b0, hsize}, {1'b0, ahb_pkg::HSIZE_WORD});
                check_ctrl("o_hburst", {1'b0, hburst}, {1'b0, ahb_pkg::HBURST_SINGLE});
                check_ctrl("o_hprot", hprot, ahb_pkg::HPROT_DATA_PRIV);
                check_ctrl("o_hwrite", {3'b000, hwrite}, 4'h0);
                check_ctrl("o_hmastlock", {3'b000, hmastlock}, 4'h0);
                next_fetch = next_fetch + 32'd4;
                if (stall_seen) begin
                    stall_fetches++;
                    if (stall_fetches > FIFO_DEPTH || stall_len > FILL_CYCLES) begin
                        stop_with_failure("Fetch kept going while the FIFO was full");
                    end
                end
            end
            if (retire.valid) begin
                if (stall_seen) begin
                    stop_with_failure("Instruction retired during debug stall");
                end
                exp_retire = ref_step(exp_pc, image[exp_pc[AW+1:2]]);
                check_retire(retire, exp_retire);
                exp_pc  = exp_pc + 32'd4;            // Program order
                retired = retired + 1;
            end
        end
    end

    initial begin
        rv_pkg::retire_t idle_retire;
        idle_retire = '0;
        reset_n     = 1'b0;
        debug_stall = 1'b0;
        load_program();
        repeat (10) @(negedge clk);
        check_request(htrans, haddr, ahb_pkg::IDLE, RESET_PC);   // Still in reset
        check_retire(retire, idle_retire);
        reset_n = 1'b1;
        wait_retired(STALL_AT);
        debug_stall = 1'b1;                          // Let the FIFO fill
        repeat (STALL_CYCLES) @(negedge clk);
        debug_stall = 1'b0;
        wait_retired(NUM_CHECK);
        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure("Errors were counted during the run");
        end
    end

endmodule : tb_top

`default_nettype wire

// ==== flist.f ====
ahb_pkg.sv
rv_pkg.sv
ahb_fetch_master.sv
fetch_fifo.sv
rv_exec_unit.sv
rv_fetch_exec_top.sv
tb_ahb_mem.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RV32I fetch/execute testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f flist.f
./obj_dir/Vtb_top
